/* source/serial_pkg.sv */
// Serial engine shared types
package serial_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int XLEN_DEFAULT = 32;  // serial word length

    typedef logic [3:0] reg_idx_t;  // x0 .. x15

    // ------------------------------
    // command encoding
    // ------------------------------
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_LI  = 3'd5   // result taken from the immediate stream
    } alu_op_e;

    typedef struct packed {
        alu_op_e  op;   // bits 14:12
        reg_idx_t rd;   // bits 11:8
        reg_idx_t rs1;  // bits 7:4
        reg_idx_t rs2;  // bits 3:0
    } cmd_t;

    // ------------------------------
    // host register map
    // ------------------------------
    typedef enum logic [1:0] {
        ADDR_IMM    = 2'd0,
        ADDR_CMD    = 2'd1,
        ADDR_STATUS = 2'd2,
        ADDR_RESULT = 2'd3
    } wb_addr_e;

    typedef struct packed {
        logic busy;     // bit 1
        logic overrun;  // bit 0 sticky until a status read
    } status_t;

endpackage

/* source/serial_regfile.sv */
// Bit-serial RV32E register file
module serial_regfile #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 pause,     // stop the ring
    input  logic                 wr_en,     // write data_rd into rd

    input  serial_pkg::reg_idx_t rs1,
    input  serial_pkg::reg_idx_t rs2,
    input  serial_pkg::reg_idx_t rd,

    output logic                 data_rs1,
    output logic                 data_rs2,
    input  logic                 data_rd
);

    localparam int AW = $clog2(XLEN);

    // one entry per bit position, one column per register x1..x15
    logic [15:1]   mem [XLEN];

    logic [AW-1:0] read_idx;
    logic [AW-1:0] write_idx;
    logic          write_pause;  // pause delayed by one clock
    logic          rd_bit_rs1;
    logic          rd_bit_rs2;
    logic          wr_bit_q;     // last bit sent towards rd
    logic          fwd_rs1;
    logic          fwd_rs2;

    // ------------------------------
    // bit indices
    // ------------------------------
    // write index trails read index by one; on pause it steps once
    // more to catch up, on unpause it holds for the first clock
    always_ff @(posedge clk) begin
        if (!rstn) begin
            read_idx    <= '0;
            write_idx   <= '0;
            write_pause <= 1'b1;
        end else begin
            if (!pause)
                read_idx <= read_idx + AW'(1);
            if (!write_pause)
                write_idx <= write_idx + AW'(1);
            write_pause <= pause;
        end
    end

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wr_en && rd != '0)
            mem[write_idx][rd] <= data_rd;  // x0 writes dropped

        rd_bit_rs1 <= (rs1 == '0) ? 1'b0 : mem[read_idx][rs1];
        rd_bit_rs2 <= (rs2 == '0) ? 1'b0 : mem[read_idx][rs2];
        wr_bit_q   <= data_rd;
    end

    // read-through while the write side is still settling on rd
    assign fwd_rs1 = write_pause && (rs1 == rd) && (rd != '0);
    assign fwd_rs2 = write_pause && (rs2 == rd) && (rd != '0);

    assign data_rs1 = fwd_rs1 ? wr_bit_q : rd_bit_rs1;
    assign data_rs2 = fwd_rs2 ? wr_bit_q : rd_bit_rs2;

endmodule

/* source/serial_alu.sv */
// Bit-serial ALU
module serial_alu (
    input  logic                clk,
    input  logic                rstn,
    input  logic                first_bit,  // lsb of the word is on a/b
    input  logic                a,
    input  logic                b,
    input  logic                imm_bit,
    input  serial_pkg::alu_op_e op,
    output logic                y
);

    logic is_sub;
    logic b_eff;     // b inverted for subtract
    logic carry_q;
    logic carry_in;
    logic sum;
    logic carry_out;

    // ------------------------------
    // adder slice
    // ------------------------------
    assign is_sub = (op == serial_pkg::OP_SUB);
    assign b_eff  = is_sub ? ~b : b;

    // two's complement subtract starts with carry one
    assign carry_in  = first_bit ? is_sub : carry_q;
    assign sum       = a ^ b_eff ^ carry_in;
    assign carry_out = (a & b_eff) | (carry_in & (a ^ b_eff));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            carry_q <= 1'b0;
        end else begin
            carry_q <= carry_out;  // kept for the next bit
        end
    end

    // ------------------------------
    // result select
    // ------------------------------
    always_comb begin
        case (op)
            serial_pkg::OP_ADD: y = sum;
            serial_pkg::OP_SUB: y = sum;
            serial_pkg::OP_AND: y = a & b;
            serial_pkg::OP_OR:  y = a | b;
            serial_pkg::OP_XOR: y = a ^ b;
            serial_pkg::OP_LI:  y = imm_bit;
            default:            y = 1'b0;  // unused encodings
        endcase
    end

endmodule

/* source/op_sequencer.sv */
// Serial operation sequencer
module op_sequencer #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  serial_pkg::cmd_t     cmd,
    input  logic [31:0]          imm,
    output serial_pkg::status_t  status,
    output logic [31:0]          result,
    output logic                 pause,
    output logic                 wr_en,
    output serial_pkg::reg_idx_t rs1,
    output serial_pkg::reg_idx_t rs2,
    output serial_pkg::reg_idx_t rd,
    output serial_pkg::alu_op_e  op,
    output logic                 first_bit,
    output logic                 imm_bit,
    input  logic                 y
);

    localparam int            CW   = $clog2(XLEN + 2);
    localparam logic [CW-1:0] BITS = CW'(XLEN);
    localparam logic [CW-1:0] LAST = CW'(XLEN + 1);  // catch-up cycle

    logic             busy_q;
    logic [CW-1:0]    cnt_q;
    serial_pkg::cmd_t cmd_q;
    logic [XLEN-1:0]  imm_sr;
    logic [XLEN-1:0]  res_sr;
    logic             accept;
    logic             in_window;

    assign accept    = start && !busy_q;
    // bits 0..XLEN-1 arrive in count 1..XLEN
    assign in_window = busy_q && (cnt_q != '0) && (cnt_q <= BITS);

    // ------------------------------
    // window counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            busy_q <= accept;
            cnt_q  <= '0;
        end else begin
            cnt_q <= cnt_q + CW'(1);
            if (cnt_q == LAST)
                busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q  <= cmd;
            imm_sr <= XLEN'(imm);
        end else if (in_window) begin
            imm_sr <= imm_sr >> 1;              // next immediate bit
            res_sr <= {y, res_sr[XLEN-1:1]};    // first bit lands in bit 0
        end
    end

    // ring runs one cycle ahead of the data it delivers
    assign pause     = !(busy_q && cnt_q < BITS);
    assign wr_en     = in_window;
    assign first_bit = busy_q && (cnt_q == CW'(1));
    assign imm_bit   = imm_sr[0];

    assign rs1    = cmd_q.rs1;
    assign rs2    = cmd_q.rs2;
    assign rd     = cmd_q.rd;
    assign op     = cmd_q.op;
    assign result = 32'(res_sr);
    assign status = '{busy: busy_q, overrun: 1'b0};

endmodule

/* source/wb_host_port.sv */
// Wishbone host register port
module wb_host_port (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  serial_pkg::wb_addr_e wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack,

    output logic                 start,   // one-cycle command strobe
    output serial_pkg::cmd_t     cmd,
    output logic [31:0]          imm,
    input  logic                 busy,
    input  logic [31:0]          result
);

    logic                req;
    logic                overrun_q;
    logic [31:0]         imm_q;
    serial_pkg::cmd_t    cmd_q;
    serial_pkg::status_t status;

    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign status = '{busy: busy, overrun: overrun_q};

    // ------------------------------
    // handshake and control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_ack    <= 1'b0;
            start     <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            wb_ack <= req;
            start  <= req && wb_we && (wb_adr == serial_pkg::ADDR_CMD) && !busy;
            if (req && wb_we && wb_adr == serial_pkg::ADDR_CMD && busy)
                overrun_q <= 1'b1;     // command dropped
            else if (req && !wb_we && wb_adr == serial_pkg::ADDR_STATUS)
                overrun_q <= 1'b0;     // cleared by the read
        end
    end

    // ------------------------------
    // registers and read data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (req && wb_we) begin
            if (wb_adr == serial_pkg::ADDR_IMM)
                imm_q <= wb_dat_w;
            if (wb_adr == serial_pkg::ADDR_CMD && !busy)
                cmd_q <= serial_pkg::cmd_t'(wb_dat_w[14:0]);
        end

        if (req && !wb_we) begin
            case (wb_adr)
                serial_pkg::ADDR_IMM:    wb_dat_r <= imm_q;
                serial_pkg::ADDR_CMD:    wb_dat_r <= {17'b0, cmd_q};
                serial_pkg::ADDR_STATUS: wb_dat_r <= {30'b0, status};
                default:                 wb_dat_r <= result;
            endcase
        end
    end

    assign cmd = cmd_q;
    assign imm = imm_q;

endmodule

/* source/serial_core_top.sv */
// Serial execute engine top
module serial_core_top #(
    parameter int XLEN = serial_pkg::XLEN_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  serial_pkg::wb_addr_e wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack
);

    logic                 start;
    serial_pkg::cmd_t     cmd;
    logic [31:0]          imm;
    logic [31:0]          result;
    serial_pkg::status_t  seq_status;
    logic                 pause;
    logic                 wr_en;
    serial_pkg::reg_idx_t rs1;
    serial_pkg::reg_idx_t rs2;
    serial_pkg::reg_idx_t rd;
    serial_pkg::alu_op_e  op;
    logic                 first_bit;
    logic                 imm_bit;
    logic                 bit_rs1;
    logic                 bit_rs2;
    logic                 y;

    wb_host_port u_host (
        .clk(clk), .rstn(rstn),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .start(start), .cmd(cmd), .imm(imm),
        .busy(seq_status.busy), .result(result)
    );

    op_sequencer #(.XLEN(XLEN)) u_seq (
        .clk(clk), .rstn(rstn), .start(start), .cmd(cmd), .imm(imm),
        .status(seq_status), .result(result),
        .pause(pause), .wr_en(wr_en), .rs1(rs1), .rs2(rs2), .rd(rd),
        .op(op), .first_bit(first_bit), .imm_bit(imm_bit), .y(y)
    );

    serial_alu u_alu (
        .clk(clk), .rstn(rstn), .first_bit(first_bit),
        .a(bit_rs1), .b(bit_rs2), .imm_bit(imm_bit), .op(op), .y(y)
    );

    serial_regfile #(.XLEN(XLEN)) u_regs (
        .clk(clk), .rstn(rstn), .pause(pause), .wr_en(wr_en),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .data_rs1(bit_rs1), .data_rs2(bit_rs2), .data_rd(y)
    );

endmodule

/* test/tb_serial_tests.svh */
// Directed serial engine tests

// ------------------------------
// register helpers
// ------------------------------
task automatic load_reg(input serial_pkg::reg_idx_t rd, input logic [31:0] value);
    wb_write(serial_pkg::ADDR_IMM, value);
    run_op(serial_pkg::OP_LI, rd, 4'd0, 4'd0);
    if (rd != 4'd0)
        model[rd] = value;   // x0 keeps zero
endtask

// OR of a register with itself into x0 with the value taken from RESULT
task automatic read_reg(input serial_pkg::reg_idx_t rs, output logic [31:0] value);
    run_op(serial_pkg::OP_OR, 4'd0, rs, rs);
    wb_read(serial_pkg::ADDR_RESULT, value);
endtask

function automatic logic [31:0] alu_model(input serial_pkg::alu_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
    case (op)
        serial_pkg::OP_ADD: return a + b;   // modulo 2^32
        serial_pkg::OP_SUB: return a - b;
        serial_pkg::OP_AND: return a & b;
        serial_pkg::OP_OR:  return a | b;
        serial_pkg::OP_XOR: return a ^ b;
        default:            return 32'h0;
    endcase
endfunction

task automatic exec_and_check(input string label, input serial_pkg::alu_op_e op,
                              input serial_pkg::reg_idx_t rd,
                              input serial_pkg::reg_idx_t rs1,
                              input serial_pkg::reg_idx_t rs2);
    logic [31:0] expected;
    logic [31:0] value;
    expected = alu_model(op, model[rs1], model[rs2]);   // old operands
    run_op(op, rd, rs1, rs2);
    wb_read(serial_pkg::ADDR_RESULT, value);
    check({label, " result"}, expected, value);
    if (rd != 4'd0)
        model[rd] = expected;
    read_reg(rd, value);
    check({label, " rd read back"}, model[rd], value);
endtask

// ------------------------------
// tests
// ------------------------------
task automatic load_and_read_back();
    int          errs;
    logic [31:0] value;
    errs = errors;
    for (int i = 1; i < 16; i++) begin
        rng = xorshift(rng);
        load_reg(4'(i), rng);
    end
    for (int i = 1; i < 16; i++) begin
        read_reg(4'(i), value);
        check($sformatf("x%0d read back", i), model[i], value);
    end
    report_test("load and read back", errs);
endtask

task automatic zero_register();
    int          errs;
    logic [31:0] value;
    errs = errors;
    rng = xorshift(rng);
    load_reg(4'd5, rng);
    rng = xorshift(rng);
    load_reg(4'd0, rng | 32'h1);   // nonzero immediate that must not stick
    read_reg(4'd0, value);
    check("x0 read", 32'h0, value);
    run_op(serial_pkg::OP_OR, 4'd0, 4'd0, 4'd5);
    wb_read(serial_pkg::ADDR_RESULT, value);
    check("x0 or x5", model[5], value);
    report_test("register x0", errs);
endtask

task automatic arith_ops();
    int errs;
    errs = errors;
    load_reg(4'd1, 32'hffff_ffff);
    load_reg(4'd2, 32'h0000_0001);
    exec_and_check("all ones plus one", serial_pkg::OP_ADD, 4'd3, 4'd1, 4'd2);
    load_reg(4'd1, 32'h0000_0000);
    exec_and_check("zero minus one", serial_pkg::OP_SUB, 4'd3, 4'd1, 4'd2);
    for (int n = 0; n < 4; n++) begin
        rng = xorshift(rng);
        load_reg(4'd1, rng);
        rng = xorshift(rng);
        load_reg(4'd2, rng);
        exec_and_check("random add", serial_pkg::OP_ADD, 4'd3, 4'd1, 4'd2);
        exec_and_check("random sub", serial_pkg::OP_SUB, 4'd4, 4'd1, 4'd2);
    end
    report_test("arithmetic", errs);
endtask

task automatic logic_ops();
    int errs;
    errs = errors;
    for (int n = 0; n < 3; n++) begin
        rng = xorshift(rng);
        load_reg(4'd3, rng);
        rng = xorshift(rng);
        load_reg(4'd4, rng);
        exec_and_check("and", serial_pkg::OP_AND, 4'd5, 4'd3, 4'd4);
        exec_and_check("or", serial_pkg::OP_OR, 4'd6, 4'd3, 4'd4);
        exec_and_check("xor", serial_pkg::OP_XOR, 4'd7, 4'd3, 4'd4);
    end
    // destination aliases a source
    exec_and_check("x3 xor x4 into x3", serial_pkg::OP_XOR, 4'd3, 4'd3, 4'd4);
    exec_and_check("x3 or x4 into x4", serial_pkg::OP_OR, 4'd4, 4'd3, 4'd4);
    report_test("logic and aliasing", errs);
endtask

task automatic status_and_overrun();
    int                  errs;
    logic [31:0]         word;
    logic [31:0]         new_val;
    serial_pkg::status_t st;
    errs = errors;
    rng = xorshift(rng);
    load_reg(4'd6, rng);
    rng = xorshift(rng);
    load_reg(4'd9, rng);
    new_val = model[9] ^ 32'h5a5a_0ff0;   // differs from x9

    wb_write(serial_pkg::ADDR_IMM, new_val);
    send_cmd(serial_pkg::OP_LI, 4'd6, 4'd0, 4'd0);
    wb_read(serial_pkg::ADDR_STATUS, word);
    st = serial_pkg::status_t'(word[1:0]);
    check("busy after cmd", 32'(1'b1), 32'(st.busy));

    send_cmd(serial_pkg::OP_LI, 4'd9, 4'd0, 4'd0);   // dropped while still busy
    wb_read(serial_pkg::ADDR_STATUS, word);
    st = serial_pkg::status_t'(word[1:0]);
    check("overrun set", 32'(1'b1), 32'(st.overrun));

    // next status read comes while the engine is still busy
    wb_read(serial_pkg::ADDR_STATUS, word);
    st = serial_pkg::status_t'(word[1:0]);
    check("overrun cleared", 32'(1'b0), 32'(st.overrun));
    wait_idle();

    model[6] = new_val;
    read_reg(4'd6, word);
    check("x6 loaded", model[6], word);
    read_reg(4'd9, word);
    check("x9 unchanged", model[9], word);
    report_test("status and overrun", errs);
endtask

/* test/tb_serial_core.sv */
// Serial engine testbench
module tb_serial_core;

    localparam int CLK_PERIOD    = 40;
    localparam int NUM_TESTS     = 5;
    localparam int OPS_PER_TEST  = 40;   // upper bound on engine ops in one test
    localparam int CYCLES_PER_OP = 200;

    logic                 clk;
    logic                 rstn;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    serial_pkg::wb_addr_e wb_adr;
    logic [31:0]          wb_dat_w;
    logic [31:0]          wb_dat_r;
    logic                 wb_ack;

    int          checks;
    int          errors;
    logic [31:0] rng;          // xorshift state
    logic [31:0] model [16];   // expected register contents with x0 held at zero

    serial_core_top #(.XLEN(serial_pkg::XLEN_DEFAULT)) uut (
        .clk(clk), .rstn(rstn),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // bus access
    // ------------------------------
    task automatic wb_write(input serial_pkg::wb_addr_e addr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input serial_pkg::wb_addr_e addr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        data = wb_dat_r;   // valid while ack is high
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic send_cmd(input serial_pkg::alu_op_e op, input serial_pkg::reg_idx_t rd,
                            input serial_pkg::reg_idx_t rs1, input serial_pkg::reg_idx_t rs2);
        serial_pkg::cmd_t c;
        c = '{op: op, rd: rd, rs1: rs1, rs2: rs2};
        wb_write(serial_pkg::ADDR_CMD, {17'b0, c});
    endtask

    task automatic wait_idle();
        logic [31:0]         word;
        serial_pkg::status_t st;
        do begin
            wb_read(serial_pkg::ADDR_STATUS, word);
            st = serial_pkg::status_t'(word[1:0]);
        end while (st.busy);
    endtask

    task automatic run_op(input serial_pkg::alu_op_e op, input serial_pkg::reg_idx_t rd,
                          input serial_pkg::reg_idx_t rs1, input serial_pkg::reg_idx_t rs2);
        send_cmd(op, rd, rs1, rs2);
        wait_idle();
    endtask

    // ------------------------------
    // checking and stimulus helpers
    // ------------------------------
    task automatic check(input string msg, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s: expected %08h, got %08h", $time, msg, expected, actual);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_test(input string name, input int errs_at_start);
        if (errors == errs_at_start)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errs_at_start);
    endtask

    `include "tb_serial_tests.svh"

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        clk      = 1'b0;
        rstn     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = serial_pkg::ADDR_IMM;
        wb_dat_w = 32'h0;
        checks   = 0;
        errors   = 0;
        rng      = 32'd37;
        for (int i = 0; i < 16; i++)
            model[i] = 32'h0;

        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        load_and_read_back();
        zero_register();
        arith_ops();
        logic_ops();
        status_and_overrun();

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog budget scales with the number of tests
    initial begin
        #(NUM_TESTS * OPS_PER_TEST * CYCLES_PER_OP * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock periods",
                 NUM_TESTS * OPS_PER_TEST * CYCLES_PER_OP);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* all.f */
+incdir+test
source/serial_pkg.sv
source/serial_regfile.sv
source/serial_alu.sv
source/op_sequencer.sv
source/wb_host_port.sv
source/serial_core_top.sv
test/tb_serial_core.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary
TOP      := tb_serial_core
FILELIST := all.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := === FAIL ===

SOURCES  := $(wildcard source/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
